//--- common/pet_defs.svh
`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// Text area of the screen
`define PET_COLS 40
`define PET_ROWS 25

// Character slots per row and rows per frame, retrace included
`define PET_HTOTAL 64
`define PET_VTOTAL 32

// Offsets inside the E8xx I/O page
`define PET_IO_KEYROW 8'h10
`define PET_IO_KEYIN  8'h12
`define PET_IO_IRQ    8'h13
`define PET_IO_GFX    8'h4C

`endif

//--- common/pet_pkg.sv
package pet_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////////////////////////////

    // CPU address space is 64 KB
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    // One cell of the 1 KB screen RAM
    typedef logic [9:0]  vram_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Request structs
    ////////////////////////////////////////////////////////////////////////////

    // CPU bus and external port request
    typedef struct packed {
        cpu_addr_t addr;
        byte_t     wdata;
        logic      we;
    } bus_req_t;

    // Screen RAM request, same layout with a short address
    typedef struct packed {
        vram_addr_t addr;
        byte_t      wdata;
        logic       we;
    } vram_req_t;

    // Screen code leaving the scanner with its position on screen
    typedef struct packed {
        logic [7:0] code;
        logic [5:0] col;
        logic [4:0] row;
    } screen_char_t;

    // Scanner is either in the text area or in vertical retrace
    typedef enum logic {
        SCAN_VISIBLE,
        SCAN_RETRACE
    } scan_state_t;

endpackage

//--- video/screen_ram.sv
`timescale 1ns/100ps

module screen_ram (
    input  logic               clk,
    input  pet_pkg::vram_req_t ram_req,
    input  logic               ram_en,
    output pet_pkg::byte_t     ram_rdata
);

    // 1024 screen cells, 1000 of them shown
    pet_pkg::byte_t mem [1024];

    // Read-first
    // a write returns the old contents of the cell
    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_rdata <= mem[ram_req.addr];
            if (ram_req.we)
                mem[ram_req.addr] <= ram_req.wdata;
        end
    end

endmodule

//--- video/vram_arbiter.sv
`timescale 1ns/100ps

module vram_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    // Scanner port, never stalled
    input  pet_pkg::vram_addr_t scan_addr,
    input  logic                scan_valid,
    // CPU port
    input  pet_pkg::vram_req_t  cpu_vram_req,
    input  logic                cpu_vram_valid,
    output logic                cpu_vram_ready,
    output logic                cpu_vram_rsp_valid,
    // Single RAM port
    output pet_pkg::vram_req_t  ram_req,
    output logic                ram_en
);

    logic cpu_grant;
    logic cpu_rd_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////////////////////////////////////////

    // CPU only gets slots the scanner leaves free
    assign cpu_vram_ready = !scan_valid;
    assign cpu_grant      = cpu_vram_valid && !scan_valid;
    assign ram_en         = scan_valid || cpu_vram_valid;

    always_comb begin
        if (scan_valid) begin
            ram_req.addr  = scan_addr;
            ram_req.wdata = '0;
            ram_req.we    = 1'b0;
        end else begin
            ram_req = cpu_vram_req;
        end
    end

    // Granted CPU read answers when the RAM output turns over
    always_ff @(posedge clk) begin
        if (!rst_n)
            cpu_rd_q <= 1'b0;
        else
            cpu_rd_q <= cpu_grant && !cpu_vram_req.we;
    end

    assign cpu_vram_rsp_valid = cpu_rd_q;

endmodule

//--- video/text_scanner.sv
`timescale 1ns/100ps
`include "pet_defs.svh"

module text_scanner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ce_char,
    input  pet_pkg::byte_t        ram_rdata,
    output pet_pkg::vram_addr_t   scan_addr,
    output logic                  scan_valid,
    output pet_pkg::screen_char_t screen_char,
    output logic                  screen_valid,
    output logic                  frame_tick
);

    pet_pkg::scan_state_t state;
    logic [5:0]           col;
    logic [4:0]           row;
    logic                 row_end;
    logic                 fetch_q;
    logic [5:0]           col_q;
    logic [4:0]           row_q;

    ////////////////////////////////////////////////////////////////////////////
    // Slot and row counters
    ////////////////////////////////////////////////////////////////////////////

    assign row_end = (col == `PET_HTOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col   <= '0;
            row   <= '0;
            state <= pet_pkg::SCAN_VISIBLE;
        end else if (ce_char) begin
            col <= col + 6'd1;
            if (row_end) begin
                row <= row + 5'd1;
                // Last text row done, start retrace
                if (row == `PET_ROWS - 1)
                    state <= pet_pkg::SCAN_RETRACE;
                // Wrap to a new frame
                if (row == `PET_VTOTAL - 1) begin
                    row   <= '0;
                    state <= pet_pkg::SCAN_VISIBLE;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Screen fetch
    ////////////////////////////////////////////////////////////////////////////

    // Text columns of the visible rows only
    assign scan_valid = ce_char && (state == pet_pkg::SCAN_VISIBLE) && (col < `PET_COLS);

    // Row-major cell index, at most 999
    assign scan_addr = pet_pkg::vram_addr_t'(row * `PET_COLS)
                     + pet_pkg::vram_addr_t'(col);

    // First slot of a frame
    assign frame_tick = ce_char && (col == '0) && (row == '0);

    always_ff @(posedge clk) begin
        if (!rst_n)
            fetch_q <= 1'b0;
        else
            fetch_q <= scan_valid;
    end

    // Position follows the fetch by one cycle to meet the RAM data
    always_ff @(posedge clk) begin
        if (scan_valid) begin
            col_q <= col;
            row_q <= row;
        end
    end

    assign screen_valid     = fetch_q;
    assign screen_char.code = ram_rdata;
    assign screen_char.col  = col_q;
    assign screen_char.row  = row_q;

endmodule

//--- io/pet_io.sv
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_io (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           io_sel,
    input  pet_pkg::byte_t io_offset,
    input  pet_pkg::byte_t io_wdata,
    input  logic           io_we,
    output pet_pkg::byte_t io_rdata,
    input  pet_pkg::byte_t keyin,
    input  logic           frame_tick,
    output logic           irq,
    output logic [3:0]     keyrow,
    output logic           video_gfx
);

    logic io_wr;
    logic io_rd;

    assign io_wr = io_sel && io_we;
    assign io_rd = io_sel && !io_we;

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            keyrow    <= 4'h0;
            video_gfx <= 1'b0;
        end else if (io_wr) begin
            case (io_offset)
                // Keyboard row select for the scan matrix
                `PET_IO_KEYROW: keyrow <= io_wdata[3:0];
                // Graphic characters vs lower case
                `PET_IO_GFX:    video_gfx <= io_wdata[1];
                default:        ;
            endcase
        end
    end

    // Frame interrupt
    // a tick in the same cycle as the clearing read wins
    always_ff @(posedge clk) begin
        if (!rst_n)
            irq <= 1'b0;
        else if (frame_tick)
            irq <= 1'b1;
        else if (io_rd && (io_offset == `PET_IO_IRQ))
            irq <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////////////////////

    // Valid the cycle after the select
    always_ff @(posedge clk) begin
        if (io_rd) begin
            case (io_offset)
                `PET_IO_KEYIN: io_rdata <= keyin;
                // Status sits in bit 7
                `PET_IO_IRQ:   io_rdata <= {irq, 7'b0};
                // Unused offsets float high
                default:       io_rdata <= 8'hFF;
            endcase
        end
    end

endmodule

//--- src/bus_decode.sv
`timescale 1ns/100ps

module bus_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  pet_pkg::bus_req_t  cpu_req,
    input  logic               cpu_req_valid,
    output logic               cpu_req_ready,
    output logic               cpu_rsp_valid,
    output pet_pkg::byte_t     cpu_rsp_data,
    output pet_pkg::bus_req_t  ext_req,
    output logic               ext_req_valid,
    input  logic               ext_req_ready,
    input  logic               ext_rsp_valid,
    input  pet_pkg::byte_t     ext_rsp_data,
    output pet_pkg::vram_req_t cpu_vram_req,
    output logic               cpu_vram_valid,
    input  logic               cpu_vram_ready,
    input  logic               cpu_vram_rsp_valid,
    input  pet_pkg::byte_t     vram_rdata,
    output logic               io_sel,
    output pet_pkg::byte_t     io_offset,
    output pet_pkg::byte_t     io_wdata,
    output logic               io_we,
    input  pet_pkg::byte_t     io_rdata
);

    // Where an outstanding read will get its data from
    localparam logic [1:0] SRC_EXT  = 2'd0;
    localparam logic [1:0] SRC_VRAM = 2'd1;
    localparam logic [1:0] SRC_IO   = 2'd2;

    logic           hit_vram;
    logic           hit_io;
    logic           hit_ext;
    logic           issue;
    logic           accept;
    logic           rd_pend;
    logic [1:0]     rd_src;
    logic           vram_done;
    pet_pkg::byte_t vram_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    // 8000-8FFF video page
    assign hit_vram = (cpu_req.addr[15:12] == 4'h8);
    // E800-EFFF I/O page
    assign hit_io   = (cpu_req.addr[15:11] == 5'b1110_1);
    // Everything else is RAM or ROM outside
    assign hit_ext  = !hit_vram && !hit_io;

    // Bus stays closed while a read waits for its data
    assign issue  = cpu_req_valid && !rd_pend;
    assign accept = cpu_req_valid && cpu_req_ready;

    assign ext_req       = cpu_req;
    assign ext_req_valid = issue && hit_ext;

    // Only bits 9..0 reach the RAM so the page mirrors four times
    assign cpu_vram_req.addr  = cpu_req.addr[9:0];
    assign cpu_vram_req.wdata = cpu_req.wdata;
    assign cpu_vram_req.we    = cpu_req.we;
    assign cpu_vram_valid     = issue && hit_vram;

    assign io_sel    = issue && hit_io;
    assign io_offset = cpu_req.addr[7:0];
    assign io_wdata  = cpu_req.wdata;
    assign io_we     = cpu_req.we;

    // Ready comes from the target, I/O never stalls
    always_comb begin
        if (hit_vram)
            cpu_req_ready = !rd_pend && cpu_vram_ready;
        else if (hit_io)
            cpu_req_ready = !rd_pend;
        else
            cpu_req_ready = !rd_pend && ext_req_ready;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outstanding read tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend   <= 1'b0;
            rd_src    <= SRC_EXT;
            vram_done <= 1'b0;
        end else begin
            if (accept && !cpu_req.we) begin
                rd_pend <= 1'b1;
                rd_src  <= hit_vram ? SRC_VRAM : (hit_io ? SRC_IO : SRC_EXT);
            end else if (cpu_rsp_valid) begin
                rd_pend <= 1'b0;
            end
            // RAM data gets one register stage before the response
            vram_done <= rd_pend && (rd_src == SRC_VRAM) && cpu_vram_rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_vram_rsp_valid)
            vram_data_q <= vram_rdata;
    end

    // Response mux follows the recorded source
    always_comb begin
        cpu_rsp_valid = 1'b0;
        cpu_rsp_data  = ext_rsp_data;
        case (rd_src)
            SRC_VRAM: begin
                cpu_rsp_valid = rd_pend && vram_done;
                cpu_rsp_data  = vram_data_q;
            end
            // I/O data is registered one cycle after the select
            SRC_IO: begin
                cpu_rsp_valid = rd_pend;
                cpu_rsp_data  = io_rdata;
            end
            default: begin
                cpu_rsp_valid = rd_pend && ext_rsp_valid;
                cpu_rsp_data  = ext_rsp_data;
            end
        endcase
    end

endmodule

//--- src/pet_hw_top.sv
`timescale 1ns/100ps

module pet_hw_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ce_char,
    // CPU bus
    input  pet_pkg::bus_req_t     cpu_req,
    input  logic                  cpu_req_valid,
    output logic                  cpu_req_ready,
    output logic                  cpu_rsp_valid,
    output pet_pkg::byte_t        cpu_rsp_data,
    // External memory port, RAM and ROMs live behind it
    output pet_pkg::bus_req_t     ext_req,
    output logic                  ext_req_valid,
    input  logic                  ext_req_ready,
    input  logic                  ext_rsp_valid,
    input  pet_pkg::byte_t        ext_rsp_data,
    // Screen code stream
    output pet_pkg::screen_char_t screen_char,
    output logic                  screen_valid,
    // I/O
    output logic                  irq,
    output logic                  video_gfx,
    output logic [3:0]            keyrow,
    input  pet_pkg::byte_t        keyin
);

    // Decoder to arbiter
    pet_pkg::vram_req_t  cpu_vram_req;
    logic                cpu_vram_valid;
    logic                cpu_vram_ready;
    logic                cpu_vram_rsp_valid;

    // Scanner to arbiter, arbiter to RAM
    pet_pkg::vram_addr_t scan_addr;
    logic                scan_valid;
    pet_pkg::vram_req_t  ram_req;
    logic                ram_en;
    pet_pkg::byte_t      ram_rdata;

    // Decoder to I/O block
    logic                io_sel;
    pet_pkg::byte_t      io_offset;
    pet_pkg::byte_t      io_wdata;
    logic                io_we;
    pet_pkg::byte_t      io_rdata;
    logic                frame_tick;

    ////////////////////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////////////////////

    bus_decode u_bus_decode (
        .clk                (clk),
        .rst_n              (rst_n),
        .cpu_req            (cpu_req),
        .cpu_req_valid      (cpu_req_valid),
        .cpu_req_ready      (cpu_req_ready),
        .cpu_rsp_valid      (cpu_rsp_valid),
        .cpu_rsp_data       (cpu_rsp_data),
        .ext_req            (ext_req),
        .ext_req_valid      (ext_req_valid),
        .ext_req_ready      (ext_req_ready),
        .ext_rsp_valid      (ext_rsp_valid),
        .ext_rsp_data       (ext_rsp_data),
        .cpu_vram_req       (cpu_vram_req),
        .cpu_vram_valid     (cpu_vram_valid),
        .cpu_vram_ready     (cpu_vram_ready),
        .cpu_vram_rsp_valid (cpu_vram_rsp_valid),
        .vram_rdata         (ram_rdata),
        .io_sel             (io_sel),
        .io_offset          (io_offset),
        .io_wdata           (io_wdata),
        .io_we              (io_we),
        .io_rdata           (io_rdata)
    );

    pet_io u_pet_io (
        .clk        (clk),
        .rst_n      (rst_n),
        .io_sel     (io_sel),
        .io_offset  (io_offset),
        .io_wdata   (io_wdata),
        .io_we      (io_we),
        .io_rdata   (io_rdata),
        .keyin      (keyin),
        .frame_tick (frame_tick),
        .irq        (irq),
        .keyrow     (keyrow),
        .video_gfx  (video_gfx)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Video side
    ////////////////////////////////////////////////////////////////////////////

    vram_arbiter u_vram_arbiter (
        .clk                (clk),
        .rst_n              (rst_n),
        .scan_addr          (scan_addr),
        .scan_valid         (scan_valid),
        .cpu_vram_req       (cpu_vram_req),
        .cpu_vram_valid     (cpu_vram_valid),
        .cpu_vram_ready     (cpu_vram_ready),
        .cpu_vram_rsp_valid (cpu_vram_rsp_valid),
        .ram_req            (ram_req),
        .ram_en             (ram_en)
    );

    screen_ram u_screen_ram (
        .clk       (clk),
        .ram_req   (ram_req),
        .ram_en    (ram_en),
        .ram_rdata (ram_rdata)
    );

    text_scanner u_text_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .ce_char      (ce_char),
        .ram_rdata    (ram_rdata),
        .scan_addr    (scan_addr),
        .scan_valid   (scan_valid),
        .screen_char  (screen_char),
        .screen_valid (screen_valid),
        .frame_tick   (frame_tick)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low for 16 rising edges, released after the drive delay
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

//--- test/tb_pet_hw.sv
`timescale 1ns/100ps
`include "pet_defs.svh"

module tb_pet_hw;

    // Three frames of 4096 cycles plus margin
    localparam int CYCLE_LIMIT = 3 * 4096 + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  ce_char;
    pet_pkg::bus_req_t     cpu_req;
    logic                  cpu_req_valid;
    logic                  cpu_req_ready;
    logic                  cpu_rsp_valid;
    pet_pkg::byte_t        cpu_rsp_data;
    pet_pkg::bus_req_t     ext_req;
    logic                  ext_req_valid;
    logic                  ext_req_ready;
    logic                  ext_rsp_valid;
    pet_pkg::byte_t        ext_rsp_data;
    pet_pkg::screen_char_t screen_char;
    logic                  screen_valid;
    logic                  irq;
    logic                  video_gfx;
    logic [3:0]            keyrow;
    pet_pkg::byte_t        keyin;

    // Models
    pet_pkg::byte_t        ext_mem [65536];
    pet_pkg::byte_t        scr_model [1024];
    logic                  scr_known [1024];

    // Checker state
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    int                    cycles;
    int                    scan_idx;
    int                    codes_in_frame;
    int                    frames;
    logic                  rd_wait;
    pet_pkg::byte_t        rd_exp;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pet_hw_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .ce_char       (ce_char),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .ext_req       (ext_req),
        .ext_req_valid (ext_req_valid),
        .ext_req_ready (ext_req_ready),
        .ext_rsp_valid (ext_rsp_valid),
        .ext_rsp_data  (ext_rsp_data),
        .screen_char   (screen_char),
        .screen_valid  (screen_valid),
        .irq           (irq),
        .video_gfx     (video_gfx),
        .keyrow        (keyrow),
        .keyin         (keyin)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t ns %s got %0h expected %0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Global watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // Character clock enable, every other cycle
    always @(posedge clk) begin
        #10 ce_char <= ~ce_char;
    end

    ////////////////////////////////////////////////////////////////////////////
    // External memory model
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int             lat;
        logic           pend;
        logic           acc;
        logic           in_rst;
        pet_pkg::byte_t data;
        lat  = 0;
        pend = 1'b0;
        forever begin
            @(posedge clk);
            acc    = ext_req_valid && ext_req_ready;
            in_rst = !rst_n;
            if (acc) begin
                // Request must pass through untouched
                assert (ext_req === cpu_req)
                    else report_mismatch("ext_req", ext_req, cpu_req);
                if (ext_req.we)
                    ext_mem[ext_req.addr] = ext_req.wdata;
                else
                    data = ext_mem[ext_req.addr];
            end
            #10;
            ext_rsp_valid = 1'b0;
            // Random ready gaps, about one cycle in four
            // Always ready while reset is applied
            ext_req_ready = in_rst || (($urandom % 4) != 0);
            if (pend) begin
                lat--;
                if (lat == 0) begin
                    ext_rsp_valid = 1'b1;
                    ext_rsp_data  = data;
                    pend          = 1'b0;
                end
            end
            if (acc && !ext_req.we) begin
                pend = 1'b1;
                lat  = 1 + ($urandom % 6);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////////////////////

    // CPU responses only for an issued read, with the model value
    always @(posedge clk) begin
        if (rst_n && cpu_rsp_valid) begin
            assert (rd_wait) else report_error("response without an outstanding read");
            assert (cpu_rsp_data === rd_exp)
                else report_mismatch("cpu_rsp_data", cpu_rsp_data, rd_exp);
        end
    end

    // No external request for the video or I/O page
    always @(posedge clk) begin
        if (rst_n && ext_req_valid)
            assert (ext_req.addr[15:12] != 4'h8 && ext_req.addr[15:11] != 5'b11101)
                else report_error("external request for an internal page");
    end

    // Screen stream in row-major order matching the screen model
    always @(posedge clk) begin
        if (rst_n && screen_valid) begin
            assert (screen_char.row == scan_idx / `PET_COLS)
                else report_mismatch("screen_char.row", screen_char.row,
                                     scan_idx / `PET_COLS);
            assert (screen_char.col == scan_idx % `PET_COLS)
                else report_mismatch("screen_char.col", screen_char.col,
                                     scan_idx % `PET_COLS);
            if (scr_known[scan_idx])
                assert (screen_char.code === scr_model[scan_idx])
                    else report_mismatch("screen_char.code", screen_char.code,
                                         scr_model[scan_idx]);
            scan_idx       <= (scan_idx == 999) ? 0 : scan_idx + 1;
            codes_in_frame <= codes_in_frame + 1;
        end
    end

    // Whole frame of codes between two frame ticks
    always @(posedge clk) begin
        if (rst_n && dut.u_text_scanner.frame_tick) begin
            if (frames > 0)
                assert (codes_in_frame == 1000)
                    else report_mismatch("codes per frame", codes_in_frame, 1000);
            codes_in_frame <= 0;
            frames         <= frames + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks, entered and left 10 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic cpu_write(input pet_pkg::cpu_addr_t a, input pet_pkg::byte_t d);
        cpu_req.addr  = a;
        cpu_req.wdata = d;
        cpu_req.we    = 1'b1;
        cpu_req_valid = 1'b1;
        do @(posedge clk); while (!cpu_req_ready);
        // Screen page mirrors on the low 10 bits
        if (a[15:12] == 4'h8) begin
            scr_model[a[9:0]] <= d;
            scr_known[a[9:0]] <= 1'b1;
        end
        #10 cpu_req_valid = 1'b0;
    endtask

    task automatic cpu_read(input pet_pkg::cpu_addr_t a, input pet_pkg::byte_t exp);
        cpu_req.addr  = a;
        cpu_req.wdata = 8'h00;
        cpu_req.we    = 1'b0;
        cpu_req_valid = 1'b1;
        do @(posedge clk); while (!cpu_req_ready);
        #10;
        cpu_req_valid = 1'b0;
        rd_exp        = exp;
        rd_wait       = 1'b1;
        do @(posedge clk); while (!cpu_rsp_valid);
        rd_wait <= 1'b0;
        #10;
    endtask

    task automatic wait_frame();
        do @(posedge clk); while (!dut.u_text_scanner.frame_tick);
        #10;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                  e0;
        pet_pkg::cpu_addr_t  a;
        pet_pkg::byte_t      d;
        void'($urandom(65368));
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        scan_idx = 0;
        codes_in_frame = 0;
        frames = 0;
        rd_wait = 1'b0;
        rd_exp = 8'h00;
        ce_char = 1'b0;
        cpu_req = '0;
        cpu_req_valid = 1'b0;
        ext_req_ready = 1'b1;
        ext_rsp_valid = 1'b0;
        ext_rsp_data = 8'h00;
        keyin = 8'h00;
        // Fill depends on all 16 address bits
        for (int i = 0; i < 65536; i++)
            ext_mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
        for (int i = 0; i < 1024; i++) begin
            scr_model[i] = 8'h00;
            scr_known[i] = 1'b0;
        end
        @(posedge rst_n);
        @(posedge clk);
        // Outputs after reset, seen at the first edge with reset released
        assert (cpu_req_ready && !ext_req_valid && !cpu_rsp_valid && !irq)
            else report_error("handshake or irq outputs wrong after reset");
        assert (keyrow == 4'h0 && !video_gfx && !screen_valid)
            else report_error("I/O or screen outputs not cleared by reset");
        #10;

        // Mirrors of the screen page
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = 16'h8000 | 16'($urandom % 1024);
            d = 8'($urandom);
            cpu_write(a, d);
            for (int m = 0; m < 4; m++)
                cpu_read({4'h8, m[1:0], a[9:0]}, d);
        end
        finish_test("screen mirrors", e0);

        // Fill the whole screen while scanning, then watch a clean frame
        e0 = errors;
        for (int i = 0; i < 1024; i++)
            cpu_write(16'h8000 | 16'(i) | 16'(($urandom % 4) << 10), 8'($urandom));
        wait_frame();
        wait_frame();
        finish_test("screen stream", e0);

        // Reads of the screen in the visible part of a frame
        e0 = errors;
        for (int i = 0; i < 64; i++) begin
            a = 16'h8000 | 16'($urandom % 4096);
            cpu_read(a, scr_model[a[9:0]]);
        end
        finish_test("screen reads while scanning", e0);

        // I/O page
        e0 = errors;
        cpu_write(16'hE800 | 16'(`PET_IO_KEYROW), 8'h37);
        assert (keyrow == 4'h7) else report_mismatch("keyrow", keyrow, 4'h7);
        keyin = 8'($urandom);
        cpu_read(16'hE800 | 16'(`PET_IO_KEYIN), keyin);
        cpu_read(16'hE800 | 16'h20, 8'hFF);
        assert (irq) else report_error("irq not set after a frame");
        cpu_read(16'hE800 | 16'(`PET_IO_IRQ), 8'h80);
        assert (!irq) else report_error("irq still high after status read");
        cpu_read(16'hE800 | 16'(`PET_IO_IRQ), 8'h00);
        cpu_write(16'hE800 | 16'(`PET_IO_GFX), 8'h02);
        assert (video_gfx) else report_mismatch("video_gfx", video_gfx, 1);
        cpu_write(16'hE800 | 16'(`PET_IO_GFX), 8'hFD);
        assert (!video_gfx) else report_mismatch("video_gfx", video_gfx, 0);
        finish_test("I/O block", e0);

        // External port with random latency and ready gaps
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            do
                a = 16'($urandom);
            while (a[15:12] == 4'h8 || a[15:11] == 5'b11101);
            if ($urandom % 2)
                cpu_write(a, 8'($urandom));
            cpu_read(a, ext_mem[a]);
        end
        finish_test("external port", e0);

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/pet_pkg.sv
video/screen_ram.sv
video/vram_arbiter.sv
video/text_scanner.sv
io/pet_io.sv
src/bus_decode.sv
src/pet_hw_top.sv
test/tb_clock.sv
test/tb_pet_hw.sv

//--- Bender.yml
package:
  name: pet_hw

sources:
  - include_dirs:
      - common
    files:
      - common/pet_pkg.sv
      - video/screen_ram.sv
      - video/vram_arbiter.sv
      - video/text_scanner.sv
      - io/pet_io.sv
      - src/bus_decode.sv
      - src/pet_hw_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock.sv
      - test/tb_pet_hw.sv
